//--- include/tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned checkCount;
int unsigned errorCount;

function automatic void tally(input bit ok, input string what, input string detail);
    checkCount++;
    if (!ok) begin
        errorCount++;
        $display("CHECK FAILED at %0t: %s %s", $time, what, detail);
    end
endfunction

// DataWidth comes from the including testbench
task automatic checkWord(input string what, input logic [DataWidth-1:0] got,
                         input logic [DataWidth-1:0] exp);
    tally(got === exp, what, $sformatf("got %h exp %h", got, exp));
endtask

task automatic checkBit(input string what, input logic got, input logic exp);
    tally(got === exp, what, $sformatf("got %b exp %b", got, exp));
endtask

task automatic checkAluOp(input string what, input aluOpT got, input aluOpT exp);
    tally(got === exp, what, $sformatf("got %s exp %s", got.name(), exp.name()));
endtask

task automatic checkMemSize(input string what, input memSizeT got, input memSizeT exp);
    tally(got === exp, what, $sformatf("got %s exp %s", got.name(), exp.name()));
endtask

task automatic checkPcSrc(input string what, input pcSrcT got, input pcSrcT exp);
    tally(got === exp, what, $sformatf("got %s exp %s", got.name(), exp.name()));
endtask

task automatic checkWb(input string what, input wbCtrlT got, input wbCtrlT exp);
    tally(got === exp, what, $sformatf("got %p exp %p", got, exp));
endtask

`endif

//--- bench/controlTopTb.sv
`timescale 1ns/10ps

module controlTopTb import rvIsaPkg::*, ctrlPkg::*;;

    localparam int DataWidth = 32;
    localparam int RomDepth  = 64;
    localparam int AddrBits  = $clog2(RomDepth);
    localparam int MaxCycles = 5000;

    `include "tbChecks.svh"

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 enF;
    logic                 enD;
    logic                 flushD;
    logic                 flushE;
    logic [DataWidth-1:0] pcF;
    logic [DataWidth-1:0] pcPlus4F;
    logic                 zeroE;

    logic [DataWidth-1:0] instrD;
    logic [DataWidth-1:0] pcD;
    logic [DataWidth-1:0] pcPlus4D;
    logic [DataWidth-1:0] immD;
    aluOpT                aluOpE;
    logic                 aluSrcImmE;
    pcSrcT                pcSrcE;
    memSizeT              storeSizeM;
    wbCtrlT               wbCtrlW;

    // own copy of the rom image plus the expected stage contents
    logic [31:0]          romModel [RomDepth];
    int                   progWords;
    logic [DataWidth-1:0] expInstrD;
    logic [DataWidth-1:0] expPcD;
    logic [DataWidth-1:0] expPc4D;
    decCtrlT              expCtrlE;
    memCtrlT              expMemM;
    wbCtrlT               expWbW;

    controlTop #(.DataWidth(DataWidth), .RomDepth(RomDepth)) dut_i (
        .clk          (clk),
        .rstN_i       (rstN),
        .enF_i        (enF),
        .enD_i        (enD),
        .flushD_i     (flushD),
        .flushE_i     (flushE),
        .pcF_i        (pcF),
        .pcPlus4F_i   (pcPlus4F),
        .zeroE_i      (zeroE),
        .instrD_o     (instrD),
        .pcD_o        (pcD),
        .pcPlus4D_o   (pcPlus4D),
        .immD_o       (immD),
        .aluOpE_o     (aluOpE),
        .aluSrcImmE_o (aluSrcImmE),
        .pcSrcE_o     (pcSrcE),
        .storeSizeM_o (storeSizeM),
        .wbCtrlW_o    (wbCtrlW)
    );

    always #10 clk = ~clk;

    function automatic memSizeT sizeFor(input logic [2:0] f3);
        case (f3[1:0])
            2'b00:   return MEM_BYTE;
            2'b01:   return MEM_HALF;
            default: return MEM_WORD; // lw and the unused 11 code
        endcase
    endfunction

    function automatic aluOpT aluOpFor(input logic [2:0] f3, input logic isSub);
        case (f3)
            3'b000:         return isSub ? ALU_SUB : ALU_ADD;
            3'b001:         return ALU_SLL;
            3'b010, 3'b011: return ALU_SLT;
            3'b100:         return ALU_XOR;
            3'b101:         return ALU_SRL; // sra too
            3'b110:         return ALU_OR;
            default:        return ALU_AND;
        endcase
    endfunction

    function automatic decCtrlT decodeExpect(input logic [31:0] w);
        decCtrlT c;
        c        = DEC_CTRL_NONE;
        c.funct3 = w[14:12];
        case (w[6:0])
            OPC_OP, OPC_OP_IMM: begin
                c.regWrite  = 1'b1;
                c.aluSrcImm = (w[6:0] == OPC_OP_IMM);
                c.aluOp     = aluOpFor(w[14:12], (w[6:0] == OPC_OP) && w[30]);
            end
            OPC_LOAD: begin
                c.regWrite  = 1'b1;
                c.loadSize  = sizeFor(w[14:12]);
                c.resultSrc = RES_MEM;
                c.aluSrcImm = 1'b1;
            end
            OPC_STORE: begin
                c.storeSize = sizeFor(w[14:12]);
                c.aluSrcImm = 1'b1;
            end
            OPC_BRANCH: begin
                c.branch = 1'b1;
                c.aluOp  = w[14] ? ALU_SLT : ALU_SUB;
            end
            OPC_JAL, OPC_JALR: begin
                c.regWrite  = 1'b1;
                c.jump      = 1'b1;
                c.resultSrc = RES_PC4;
                c.aluSrcImm = (w[6:0] == OPC_JALR);
            end
            OPC_LUI, OPC_AUIPC: begin
                c.regWrite  = 1'b1;
                c.aluSrcImm = 1'b1;
            end
            default: c = DEC_CTRL_NONE; // unsupported opcode
        endcase
        return c;
    endfunction

    function automatic logic [31:0] immFor(input logic [31:0] w);
        case (w[6:0])
            OPC_STORE:          return {{20{w[31]}}, w[31:25], w[11:7]};
            OPC_BRANCH:         return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPC_JAL:            return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OPC_LUI, OPC_AUIPC: return {w[31:12], 12'h000};
            default:            return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    function automatic pcSrcT pcSrcFor(input decCtrlT c, input logic zero);
        if (c.jump) begin
            return PC_JUMP;
        end
        if (c.branch && (c.funct3[0] ? !zero : zero)) begin
            return PC_BRANCH;
        end
        return PC_NEXT;
    endfunction

    task automatic compareOutputs();
        checkWord("instrD", instrD, expInstrD);
        checkWord("pcD", pcD, expPcD);
        checkWord("pcPlus4D", pcPlus4D, expPc4D);
        checkWord("immD", immD, immFor(expInstrD));
        checkAluOp("aluOpE", aluOpE, expCtrlE.aluOp);
        checkBit("aluSrcImmE", aluSrcImmE, expCtrlE.aluSrcImm);
        checkPcSrc("pcSrcE", pcSrcE, pcSrcFor(expCtrlE, zeroE));
        checkMemSize("storeSizeM", storeSizeM, expMemM.storeSize);
        checkWb("wbCtrlW", wbCtrlW, expWbW);
    endtask

    // expected pipeline steps on the edge and is compared 5 ns before the next one
    always begin
        @(posedge clk);
        if (!rstN) begin
            expInstrD = NOP_INSTR;
            expPcD    = '0;
            expPc4D   = '0;
            expCtrlE  = DEC_CTRL_NONE;
            expMemM   = MEM_CTRL_NONE;
            expWbW    = WB_CTRL_NONE;
        end else begin
            expWbW  = '{regWrite: expMemM.regWrite, loadSize: expMemM.loadSize,
                        resultSrc: expMemM.resultSrc};
            expMemM = '{regWrite: expCtrlE.regWrite, loadSize: expCtrlE.loadSize,
                        storeSize: expCtrlE.storeSize, resultSrc: expCtrlE.resultSrc};
            if (flushE) begin
                expCtrlE = DEC_CTRL_NONE;
            end else if (enD) begin
                expCtrlE = decodeExpect(expInstrD);
            end
            if (flushD) begin
                expInstrD = NOP_INSTR;
                expPcD    = '0;
                expPc4D   = '0;
            end else if (enF) begin
                expInstrD = romModel[pcF[AddrBits+1:2]];
                expPcD    = pcF;
                expPc4D   = pcPlus4F;
            end
        end
        #15;
        compareOutputs();
    end

    task automatic issue(input logic [DataWidth-1:0] pcVal, input logic fetchEn,
                         input logic decodeEn, input logic flushDec, input logic flushExe);
        @(negedge clk);
        pcF      = pcVal;
        pcPlus4F = pcVal + DataWidth'(4);
        enF      = fetchEn;
        enD      = decodeEn;
        flushD   = flushDec;
        flushE   = flushExe;
        zeroE    = ($urandom % 2) == 1;
    endtask

    task automatic waitWbIdle(input int limit);
        int n;
        n = 0;
        while (wbCtrlW.regWrite !== 1'b0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (wbCtrlW.regWrite !== 1'b0) begin
            $display("timeout: writeback still writes %0d cycles after the flush", limit);
            errorCount++;
        end
    endtask

    // bubbles through both flushable registers and waits for writeback
    task automatic drain();
        repeat (4) issue('0, 1'b0, 1'b0, 1'b1, 1'b1);
        waitWbIdle(8);
    endtask

    task automatic finishTest(input string name, input int unsigned errsBefore);
        if (errorCount == errsBefore) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errorCount - errsBefore);
        end
    endtask

    initial begin
        int          idx;
        int          n;
        logic        stall;
        int unsigned mark;
        void'($urandom(32'h2a7f_74fb));
        rstN     = 1'b0;
        enF      = 1'b0;
        enD      = 1'b0;
        flushD   = 1'b0;
        flushE   = 1'b0;
        pcF      = '0;
        pcPlus4F = '0;
        zeroE    = 1'b0;

        for (n = 0; n < RomDepth; n++) begin
            romModel[n] = 32'hBAD0_0000 | 32'(n); // marks words the image leaves out
        end
        $readmemh("prog.hex", romModel);
        progWords = 0;
        while (progWords < RomDepth &&
               romModel[progWords] !== (32'hBAD0_0000 | 32'(progWords))) begin
            progWords++;
        end
        if (progWords == 0) begin
            $display("prog.hex held no instruction words");
            errorCount++;
        end

        repeat (5) @(negedge clk);
        rstN = 1'b1;

        mark = errorCount;
        checkBit("reset wb regWrite", wbCtrlW.regWrite, 1'b0);
        checkMemSize("reset storeSizeM", storeSizeM, MEM_NONE);
        checkPcSrc("reset pcSrcE", pcSrcE, PC_NEXT);
        finishTest("reset", mark);

        mark = errorCount;
        for (idx = 0; idx < progWords; idx++) begin
            issue(DataWidth'(idx * 4), 1'b1, 1'b1, 1'b0, 1'b0);
        end
        drain();
        finishTest("sequential", mark);

        // pc only moves on when the front end is not held
        mark = errorCount;
        idx  = 0;
        for (n = 0; n < 3 * progWords; n++) begin
            stall = ($urandom % 4) == 0;
            issue(DataWidth'(idx * 4), !stall, !stall, 1'b0, 1'b0);
            if (!stall) begin
                idx = (idx + 1) % progWords;
            end
        end
        drain();
        finishTest("stall", mark);

        mark = errorCount;
        for (n = 0; n < 2 * progWords; n++) begin
            issue(DataWidth'((n % progWords) * 4), 1'b1, 1'b1,
                  ($urandom % 5) == 0, ($urandom % 5) == 0);
        end
        drain();
        finishTest("flush", mark);

        mark = errorCount;
        for (idx = 0; idx < progWords; idx++) begin
            if (romModel[idx][6:0] == OPC_BRANCH || romModel[idx][6:0] == OPC_JAL ||
                romModel[idx][6:0] == OPC_JALR) begin
                repeat (4) issue(DataWidth'(idx * 4), 1'b1, 1'b1, 1'b0, 1'b0);
            end
        end
        drain();
        finishTest("branch select", mark);

        mark = errorCount;
        for (idx = 0; idx < progWords; idx++) begin
            if (romModel[idx][6:0] == OPC_LOAD || romModel[idx][6:0] == OPC_STORE) begin
                issue(DataWidth'(idx * 4), 1'b1, 1'b1, 1'b0, 1'b0);
            end
        end
        drain();
        finishTest("memory size", mark);

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(20 * MaxCycles);
        $display("timeout: run exceeded %0d clock cycles", MaxCycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- logic/controlTop.sv
`timescale 1ns/10ps

module controlTop import rvIsaPkg::*, ctrlPkg::*; #(
    parameter int DataWidth = 32,
    parameter int RomDepth  = 64
) (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  logic                 enF_i,
    input  logic                 enD_i,
    input  logic                 flushD_i,
    input  logic                 flushE_i,
    input  logic [DataWidth-1:0] pcF_i,
    input  logic [DataWidth-1:0] pcPlus4F_i,
    input  logic                 zeroE_i,
    output logic [DataWidth-1:0] instrD_o,
    output logic [DataWidth-1:0] pcD_o,
    output logic [DataWidth-1:0] pcPlus4D_o,
    output logic [DataWidth-1:0] immD_o,
    output aluOpT                aluOpE_o,
    output logic                 aluSrcImmE_o,
    output pcSrcT                pcSrcE_o,
    output memSizeT              storeSizeM_o,
    output wbCtrlT               wbCtrlW_o
);

    decCtrlT decCtrlD;
    immFmtT  immFmtD;

    fetchStage #(.DataWidth(DataWidth), .RomDepth(RomDepth)) fetch_i (
        .clk        (clk),
        .rstN_i     (rstN_i),
        .enF_i      (enF_i),
        .flushD_i   (flushD_i),
        .pcF_i      (pcF_i),
        .pcPlus4F_i (pcPlus4F_i),
        .instrD_o   (instrD_o),
        .pcD_o      (pcD_o),
        .pcPlus4D_o (pcPlus4D_o)
    );

    mainDecoder decode_i (
        .instrD_i  (instrD_o[31:0]),
        .decCtrl_o (decCtrlD),
        .immFmt_o  (immFmtD)
    );

    immExtender #(.DataWidth(DataWidth)) immExt_i (
        .instrD_i (instrD_o),
        .immFmt_i (immFmtD),
        .immD_o   (immD_o)
    );

    execCtrlPipe execPipe_i (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .enD_i        (enD_i),
        .flushE_i     (flushE_i),
        .decCtrlD_i   (decCtrlD),
        .zeroE_i      (zeroE_i),
        .aluOpE_o     (aluOpE_o),
        .aluSrcImmE_o (aluSrcImmE_o),
        .pcSrcE_o     (pcSrcE_o),
        .storeSizeM_o (storeSizeM_o),
        .wbCtrlW_o    (wbCtrlW_o)
    );

endmodule

//--- logic/ctrlPkg.sv
package ctrlPkg;

    import rvIsaPkg::*;

    typedef enum logic [1:0] {MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD} memSizeT;
    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} resultSrcT;
    typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_JUMP} pcSrcT;

    typedef struct packed {
        logic       regWrite;
        memSizeT    loadSize;
        memSizeT    storeSize;
        resultSrcT  resultSrc;
        aluOpT      aluOp;
        logic       aluSrcImm;
        logic       jump;
        logic       branch;
        logic [2:0] funct3;     // needed in execute for the branch sense
    } decCtrlT;

    typedef struct packed {
        logic      regWrite;
        memSizeT   loadSize;
        memSizeT   storeSize;
        resultSrcT resultSrc;
    } memCtrlT;

    typedef struct packed {
        logic      regWrite;
        memSizeT   loadSize;
        resultSrcT resultSrc;
    } wbCtrlT;

    localparam decCtrlT DEC_CTRL_NONE = '{regWrite: 1'b0, loadSize: MEM_NONE,
        storeSize: MEM_NONE, resultSrc: RES_ALU, aluOp: ALU_ADD, aluSrcImm: 1'b0,
        jump: 1'b0, branch: 1'b0, funct3: 3'b000};
    localparam memCtrlT MEM_CTRL_NONE = '{regWrite: 1'b0, loadSize: MEM_NONE,
        storeSize: MEM_NONE, resultSrc: RES_ALU};
    localparam wbCtrlT WB_CTRL_NONE = '{regWrite: 1'b0, loadSize: MEM_NONE,
        resultSrc: RES_ALU};

endpackage

//--- logic/execCtrlPipe.sv
`timescale 1ns/10ps

module execCtrlPipe import rvIsaPkg::*, ctrlPkg::*; (
    input  logic    clk,
    input  logic    rstN_i,
    input  logic    enD_i,
    input  logic    flushE_i,
    input  decCtrlT decCtrlD_i,
    input  logic    zeroE_i,
    output aluOpT   aluOpE_o,
    output logic    aluSrcImmE_o,
    output pcSrcT   pcSrcE_o,
    output memSizeT storeSizeM_o,
    output wbCtrlT  wbCtrlW_o
);

    decCtrlT decCtrlE;
    memCtrlT memCtrlM;
    logic    branchTaken;

    // decode -> execute
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            decCtrlE <= DEC_CTRL_NONE;
        end else if (flushE_i) begin
            decCtrlE <= DEC_CTRL_NONE; // bubble
        end else if (enD_i) begin
            decCtrlE <= decCtrlD_i;
        end
    end

    // execute -> memory
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            memCtrlM <= MEM_CTRL_NONE;
        end else begin
            memCtrlM <= '{regWrite: decCtrlE.regWrite, loadSize: decCtrlE.loadSize,
                          storeSize: decCtrlE.storeSize, resultSrc: decCtrlE.resultSrc};
        end
    end

    // memory -> writeback
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            wbCtrlW_o <= WB_CTRL_NONE;
        end else begin
            wbCtrlW_o <= '{regWrite: memCtrlM.regWrite, loadSize: memCtrlM.loadSize,
                           resultSrc: memCtrlM.resultSrc};
        end
    end

    // funct3 bit 0 inverts the sense for bne, bge and bgeu
    assign branchTaken = decCtrlE.branch & (zeroE_i ^ decCtrlE.funct3[0]);

    always_comb begin
        if (decCtrlE.jump) begin
            pcSrcE_o = PC_JUMP;
        end else if (branchTaken) begin
            pcSrcE_o = PC_BRANCH;
        end else begin
            pcSrcE_o = PC_NEXT;
        end
    end

    assign aluOpE_o     = decCtrlE.aluOp;
    assign aluSrcImmE_o = decCtrlE.aluSrcImm;
    assign storeSizeM_o = memCtrlM.storeSize;

    jumpNeedsJumpE: assert property (
        @(posedge clk) disable iff (!rstN_i)
        (pcSrcE_o == PC_JUMP) |-> decCtrlE.jump
    ) else $error("pc source JUMP without a jump in execute");

endmodule

//--- logic/fetchStage.sv
`timescale 1ns/10ps

module fetchStage import rvIsaPkg::*; #(
    parameter int DataWidth = 32,
    parameter int RomDepth  = 64
) (
    input  logic                 clk,
    input  logic                 rstN_i,
    input  logic                 enF_i,
    input  logic                 flushD_i,
    input  logic [DataWidth-1:0] pcF_i,
    input  logic [DataWidth-1:0] pcPlus4F_i,
    output logic [DataWidth-1:0] instrD_o,
    output logic [DataWidth-1:0] pcD_o,
    output logic [DataWidth-1:0] pcPlus4D_o
);

    localparam int AddrBits = $clog2(RomDepth);
    localparam logic [DataWidth-1:0] NopWord = DataWidth'(NOP_INSTR);

    logic [DataWidth-1:0] rom [RomDepth];
    logic [DataWidth-1:0] instrF;

    initial begin
        $readmemh("prog.hex", rom);
    end

    // word addressed and wrapping past the rom end
    assign instrF = rom[pcF_i[AddrBits+1:2]];

    // fetch/decode register where flush beats a held stage
    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            instrD_o   <= NopWord;
            pcD_o      <= '0;
            pcPlus4D_o <= '0;
        end else if (flushD_i) begin
            instrD_o   <= NopWord;
            pcD_o      <= '0;
            pcPlus4D_o <= '0;
        end else if (enF_i) begin
            instrD_o   <= instrF;
            pcD_o      <= pcF_i;
            pcPlus4D_o <= pcPlus4F_i;
        end
    end

    pcAligned: assert property (
        @(posedge clk) disable iff (!rstN_i)
        enF_i |-> (pcF_i[1:0] == 2'b00)
    ) else $error("fetch from misaligned pc %h", pcF_i);

endmodule

//--- logic/immExtender.sv
`timescale 1ns/10ps

module immExtender import rvIsaPkg::*; #(
    parameter int DataWidth = 32
) (
    input  logic [DataWidth-1:0] instrD_i,
    input  immFmtT               immFmt_i,
    output logic [DataWidth-1:0] immD_o
);

    logic [31:0] imm32;

    always_comb begin
        case (immFmt_i)
            IMM_I: imm32 = {{20{instrD_i[31]}}, instrD_i[31:20]};
            IMM_S: imm32 = {{20{instrD_i[31]}}, instrD_i[31:25], instrD_i[11:7]};
            IMM_B: imm32 = {{19{instrD_i[31]}}, instrD_i[31], instrD_i[7],
                            instrD_i[30:25], instrD_i[11:8], 1'b0};
            IMM_U: imm32 = {instrD_i[31:12], 12'b0};
            IMM_J: imm32 = {{11{instrD_i[31]}}, instrD_i[31], instrD_i[19:12],
                            instrD_i[20], instrD_i[30:21], 1'b0};
            default: imm32 = '0;
        endcase
    end

    // widen to the datapath width keeping the sign
    assign immD_o = DataWidth'(signed'(imm32));

endmodule

//--- logic/mainDecoder.sv
`timescale 1ns/10ps

module mainDecoder import rvIsaPkg::*, ctrlPkg::*; (
    input  logic [31:0] instrD_i,
    output decCtrlT     decCtrl_o,
    output immFmtT      immFmt_o
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    aluOpT      aluFunc;

    assign opcode   = opcodeT'(instrD_i[6:0]);
    assign funct3   = instrD_i[14:12];
    assign funct7b5 = instrD_i[30];

    function automatic memSizeT sizeOf(input logic [1:0] width);
        case (width)
            2'b00:   return MEM_BYTE;
            2'b01:   return MEM_HALF;
            default: return MEM_WORD;
        endcase
    endfunction

    // alu op shared by OP and OP_IMM
    always_comb begin
        case (funct3)
            F3_ADD_SUB:      aluFunc = (opcode == OPC_OP && funct7b5) ? ALU_SUB : ALU_ADD;
            F3_SLL:          aluFunc = ALU_SLL;
            F3_SLT, F3_SLTU: aluFunc = ALU_SLT;
            F3_XOR:          aluFunc = ALU_XOR;
            F3_SRL_SRA:      aluFunc = ALU_SRL;  // sra folds onto srl
            F3_OR:           aluFunc = ALU_OR;
            default:         aluFunc = ALU_AND;
        endcase
    end

    always_comb begin
        decCtrl_o        = DEC_CTRL_NONE;
        decCtrl_o.funct3 = funct3;
        immFmt_o         = IMM_I;
        case (opcode)
            OPC_OP: begin
                decCtrl_o.regWrite = 1'b1;
                decCtrl_o.aluOp    = aluFunc;
            end
            OPC_OP_IMM: begin
                decCtrl_o.regWrite  = 1'b1;
                decCtrl_o.aluOp     = aluFunc;
                decCtrl_o.aluSrcImm = 1'b1;
            end
            OPC_LOAD: begin
                decCtrl_o.regWrite  = 1'b1;
                decCtrl_o.loadSize  = sizeOf(funct3[1:0]);
                decCtrl_o.resultSrc = RES_MEM;
                decCtrl_o.aluSrcImm = 1'b1;
            end
            OPC_STORE: begin
                decCtrl_o.storeSize = sizeOf(funct3[1:0]);
                decCtrl_o.aluSrcImm = 1'b1;
                immFmt_o            = IMM_S;
            end
            OPC_BRANCH: begin
                decCtrl_o.branch = 1'b1;
                decCtrl_o.aluOp  = funct3[2] ? ALU_SLT : ALU_SUB; // beq/bne compare by sub
                immFmt_o         = IMM_B;
            end
            OPC_JAL: begin
                decCtrl_o.regWrite  = 1'b1;
                decCtrl_o.jump      = 1'b1;
                decCtrl_o.resultSrc = RES_PC4;
                immFmt_o            = IMM_J;
            end
            OPC_JALR: begin
                decCtrl_o.regWrite  = 1'b1;
                decCtrl_o.jump      = 1'b1;
                decCtrl_o.resultSrc = RES_PC4;
                decCtrl_o.aluSrcImm = 1'b1; // target is rs1 + imm
            end
            OPC_LUI, OPC_AUIPC: begin
                decCtrl_o.regWrite  = 1'b1;
                decCtrl_o.aluSrcImm = 1'b1;
                immFmt_o            = IMM_U;
            end
            default: decCtrl_o = DEC_CTRL_NONE;
        endcase

        // a store must never also claim the register file port
        assert (!(decCtrl_o.regWrite && decCtrl_o.storeSize != MEM_NONE))
            else $error("decode sets store and regWrite for %h", instrD_i);
    end

endmodule

//--- logic/rvIsaPkg.sv
package rvIsaPkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcodeT;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immFmtT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } aluOpT;

    // funct3 codes of the OP / OP_IMM class
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

endpackage

//--- prog.hex
// instruction ROM image, one 32-bit RV32I word per line in hex
// line n holds the word fetched at pc 4*n
00500093
00108133
401101B3
12345237
FFC08283
00809303
00C0A383
002081A3
FE209F23
0030A823
00208463
FE209EE3
0020C863
00115663
010000EF
00008067
FFF0C413
00001497
40115533
0000000F

//--- run.sh
#!/usr/bin/env bash
# compile and run the control path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f tb.f --top-module controlTopTb -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ/VcontrolTopTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    exit 0
fi
exit 1

//--- tb.f
+incdir+include
logic/rvIsaPkg.sv
logic/ctrlPkg.sv
logic/fetchStage.sv
logic/mainDecoder.sv
logic/immExtender.sv
logic/execCtrlPipe.sv
logic/controlTop.sv
bench/controlTopTb.sv
